/* source/corrPkg.sv */
package corrPkg;

    //////////////////////////////////////////////////////////////////////
    // Default geometry of the correlator
    //////////////////////////////////////////////////////////////////////

    // Symbols held in one window
    parameter int defaultNumSamples = 128;

    // Oversampled bits per symbol
    parameter int defaultOsf = 8;

    //////////////////////////////////////////////////////////////////////
    // Derived widths
    //////////////////////////////////////////////////////////////////////

    // Window length in bits
    function automatic int windowBits(input int numSamples, input int osf);
        return numSamples * osf;
    endfunction

    // Holds 0 up to a full window of agreements
    function automatic int corrWidth(input int numSamples, input int osf);
        return $clog2(windowBits(numSamples, osf) + 1);
    endfunction

    // Holds 0 up to Osf
    function automatic int symbolCountWidth(input int osf);
        return $clog2(osf + 1);
    endfunction

endpackage

/* source/shiftRegister.sv */
`timescale 1ns/1ns

module shiftRegister import corrPkg::*; #(
    parameter int Width = windowBits(defaultNumSamples, defaultOsf)
) (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             shift,
    input  logic             bitIn,
    output logic [Width-1:0] window
);

    //////////////////////////////////////////////////////////////////////
    // Serial-in window
    //////////////////////////////////////////////////////////////////////

    // Newest bit enters at the MSB, oldest drops out of the LSB
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            window <= '0;
        end else if (shift) begin
            window <= {bitIn, window[Width-1:1]};
        end
    end

    // Contents hold whenever shift is low

endmodule

/* source/bitSequencer.sv */
`timescale 1ns/1ns

module bitSequencer import corrPkg::*; #(
    parameter int NumSamples = defaultNumSamples,
    parameter int Osf        = defaultOsf
) (
    input  logic Clk,
    input  logic rstN,
    input  logic bitValid,
    input  logic loadPattern,
    output logic patternShift,
    output logic sampleShift,
    output logic symbolDone
);

    localparam int WinW = windowBits(NumSamples, Osf);
    localparam int PatW = corrWidth(NumSamples, Osf);
    localparam int SymW = symbolCountWidth(Osf);

    typedef enum logic [1:0] {
        phaseIdle,
        phasePattern,
        phaseSample
    } phaseT;

    phaseT           phase;
    logic [PatW-1:0] patternCount;
    logic [SymW-1:0] symbolCount;
    logic            accept;
    logic            patternLast;
    logic            symbolLast;

    //////////////////////////////////////////////////////////////////////
    // Bit steering
    //////////////////////////////////////////////////////////////////////

    // A bit arriving together with a load request is dropped
    assign accept = bitValid && !loadPattern;

    assign patternShift = accept && (phase == phasePattern);
    assign sampleShift  = accept && (phase == phaseSample);

    // Last bit of the pattern window and of the current symbol
    assign patternLast = (patternCount == PatW'(WinW - 1));
    assign symbolLast  = (symbolCount == SymW'(Osf - 1));

    //////////////////////////////////////////////////////////////////////
    // Phase and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            phase        <= phaseIdle;
            patternCount <= '0;
            symbolCount  <= '0;
            symbolDone   <= 1'b0;
        end else begin
            // Single-cycle strobe unless set below
            symbolDone <= 1'b0;

            if (loadPattern) begin
                // Restart capture from any phase
                phase        <= phasePattern;
                patternCount <= '0;
                symbolCount  <= '0;
            end else if (patternShift) begin
                if (patternLast) begin
                    phase        <= phaseSample;
                    patternCount <= '0;
                end else begin
                    patternCount <= patternCount + PatW'(1);
                end
            end else if (sampleShift) begin
                if (symbolLast) begin
                    // Full symbol now inside the sample window
                    symbolCount <= '0;
                    symbolDone  <= 1'b1;
                end else begin
                    symbolCount <= symbolCount + SymW'(1);
                end
            end
        end
    end

    // Idle only leaves through loadPattern, so bits before it are lost

endmodule

/* source/correlationEngine.sv */
`timescale 1ns/1ns

module correlationEngine import corrPkg::*; #(
    parameter int NumSamples = defaultNumSamples,
    parameter int Osf        = defaultOsf
) (
    input  logic                                   Clk,
    input  logic                                   rstN,
    input  logic [windowBits(NumSamples, Osf)-1:0] pattern,
    input  logic [windowBits(NumSamples, Osf)-1:0] sample,
    input  logic                                   symbolDone,
    output logic [corrWidth(NumSamples, Osf)-1:0]  corrOut,
    output logic                                   corrValid
);

    localparam int WinW  = windowBits(NumSamples, Osf);
    localparam int CorrW = corrWidth(NumSamples, Osf);
    localparam int SymW  = symbolCountWidth(Osf);

    logic [WinW-1:0]                  agree;
    logic [NumSamples-1:0][SymW-1:0]  symbolCounts;
    logic [CorrW-1:0]                 total;

    // Number of set bits in one symbol
    function automatic logic [SymW-1:0] countOnes(input logic [Osf-1:0] bits);
        logic [SymW-1:0] ones;
        ones = '0;
        for (int b = 0; b < Osf; b++) begin
            ones = ones + SymW'(bits[b]);
        end
        return ones;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Agreement and per-symbol count
    //////////////////////////////////////////////////////////////////////

    // XNOR marks equal positions
    assign agree = ~(pattern ^ sample);

    for (genvar s = 0; s < NumSamples; s++) begin : gSymbol
        assign symbolCounts[s] = countOnes(agree[s*Osf +: Osf]);
    end

    //////////////////////////////////////////////////////////////////////
    // Sum over symbols
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        total = '0;
        for (int s = 0; s < NumSamples; s++) begin
            total = total + CorrW'(symbolCounts[s]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            corrOut   <= '0;
            corrValid <= 1'b0;
        end else begin
            corrValid <= symbolDone;
            // Hold last result between symbols
            if (symbolDone) begin
                corrOut <= total;
            end
        end
    end

endmodule

/* source/corrTop.sv */
`timescale 1ns/1ns

module corrTop import corrPkg::*; #(
    parameter int NumSamples = defaultNumSamples,
    parameter int Osf        = defaultOsf
) (
    input  logic                                  Clk,
    input  logic                                  rstN,
    input  logic                                  bitIn,
    input  logic                                  bitValid,
    input  logic                                  loadPattern,
    output logic [corrWidth(NumSamples, Osf)-1:0] corrOut,
    output logic                                  corrValid
);

    localparam int WinW = windowBits(NumSamples, Osf);

    logic            patternShift;
    logic            sampleShift;
    logic            symbolDone;
    logic [WinW-1:0] patternBits;
    logic [WinW-1:0] sampleBits;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    bitSequencer #(
        .NumSamples (NumSamples),
        .Osf        (Osf)
    ) sequencer0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .bitValid     (bitValid),
        .loadPattern  (loadPattern),
        .patternShift (patternShift),
        .sampleShift  (sampleShift),
        .symbolDone   (symbolDone)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference pattern and incoming samples
    //////////////////////////////////////////////////////////////////////

    // Both windows see the same serial input
    shiftRegister #(.Width(WinW)) patternWindow (
        .Clk    (Clk),
        .rstN   (rstN),
        .shift  (patternShift),
        .bitIn  (bitIn),
        .window (patternBits)
    );

    shiftRegister #(.Width(WinW)) sampleWindow (
        .Clk    (Clk),
        .rstN   (rstN),
        .shift  (sampleShift),
        .bitIn  (bitIn),
        .window (sampleBits)
    );

    //////////////////////////////////////////////////////////////////////
    // Correlation
    //////////////////////////////////////////////////////////////////////

    correlationEngine #(
        .NumSamples (NumSamples),
        .Osf        (Osf)
    ) engine0 (
        .Clk        (Clk),
        .rstN       (rstN),
        .pattern    (patternBits),
        .sample     (sampleBits),
        .symbolDone (symbolDone),
        .corrOut    (corrOut),
        .corrValid  (corrValid)
    );

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 8
) (
    output logic Clk,
    output logic rstN
);

    // Free-running clock, low for the first half period
    initial begin
        Clk = 1'b0;
        forever begin
            #(PeriodNs / 2) Clk = ~Clk;
        end
    end

    // Reset low for a fixed count of rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
    end

endmodule

/* verification/corrTb.sv */
`timescale 1ns/1ns

module corrTb
    import corrPkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // Geometry and run length
    //////////////////////////////////////////////////////////////////////

    localparam int NumSamples = 16;
    localparam int Osf        = 4;
    localparam int WinBits    = windowBits(NumSamples, Osf);
    localparam int CorrW      = corrWidth(NumSamples, Osf);
    localparam int PeriodNs   = 40;
    localparam int Seed       = 32'h07dc_7a6d;

    localparam int ResetCycles    = 8;
    localparam int DrainCycles    = 4;
    localparam int QuietCycles    = 100;
    localparam int MatchCycles    = 1 + 2 * WinBits;
    localparam int MismatchCycles = WinBits;
    localparam int RandomCycles   = 300;
    localparam int ReloadCycles   = Osf + 1 + 2 * WinBits + 2 * Osf;
    localparam int TotalCycles    = ResetCycles + 2 + QuietCycles + MatchCycles
                                  + MismatchCycles + RandomCycles + ReloadCycles
                                  + 5 * DrainCycles;
    localparam int WatchdogNs     = (TotalCycles + 50) * PeriodNs;

    // Model phases
    localparam int PhaseIdle    = 0;
    localparam int PhasePattern = 1;
    localparam int PhaseSample  = 2;

    logic             Clk;
    logic             rstN;
    logic             bitIn;
    logic             bitValid;
    logic             loadPattern;
    logic [CorrW-1:0] corrOut;
    logic             corrValid;

    // Reference model state
    int   modelPhase;
    int   modelPatternCount;
    int   modelSymbolCount;
    logic modelPattern [WinBits];
    logic modelSample [WinBits];
    logic patternSeq [WinBits];
    int   expectedValues [$];
    int   expectedCycles [$];

    int          cycleCount = 0;
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          resultCount = 0;
    logic [31:0] lastResult = '0;
    bit          checkIdle = 1'b0;

    clockGen #(
        .PeriodNs    (PeriodNs),
        .ResetCycles (ResetCycles)
    ) clockGen0 (
        .Clk  (Clk),
        .rstN (rstN)
    );

    corrTop #(
        .NumSamples (NumSamples),
        .Osf        (Osf)
    ) dut0 (
        .Clk         (Clk),
        .rstN        (rstN),
        .bitIn       (bitIn),
        .bitValid    (bitValid),
        .loadPattern (loadPattern),
        .corrOut     (corrOut),
        .corrValid   (corrValid)
    );

    // Rising edges seen so far
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic randomBit();
        return 1'($urandom % 2);
    endfunction

    // Positions where pattern and sample windows agree
    function automatic int countAgreement();
        int count;
        count = 0;
        for (int i = 0; i < WinBits; i++) begin
            if (modelPattern[i] == modelSample[i]) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    // What the DUT does on the edge that follows the drive
    task automatic updateModel(input logic valid, input logic bitVal, input logic load);
        if (load) begin
            modelPhase        = PhasePattern;
            modelPatternCount = 0;
            modelSymbolCount  = 0;
        end else if (valid && modelPhase == PhasePattern) begin
            for (int i = 0; i < WinBits - 1; i++) begin
                modelPattern[i] = modelPattern[i + 1];
            end
            modelPattern[WinBits - 1] = bitVal;
            modelPatternCount++;
            if (modelPatternCount == WinBits) begin
                modelPhase        = PhaseSample;
                modelPatternCount = 0;
            end
        end else if (valid && modelPhase == PhaseSample) begin
            for (int i = 0; i < WinBits - 1; i++) begin
                modelSample[i] = modelSample[i + 1];
            end
            modelSample[WinBits - 1] = bitVal;
            modelSymbolCount++;
            if (modelSymbolCount == Osf) begin
                // Result shows one edge after the accepting edge
                modelSymbolCount = 0;
                expectedValues.push_back(countAgreement());
                expectedCycles.push_back(cycleCount + 2);
            end
        end
    endtask

    task automatic checkOutputs();
        int expectedValue;
        int expectedCycle;
        if (corrValid === 1'b1) begin
            // Every pulse from the DUT counts, expected or not
            lastResult = 32'(corrOut);
            resultCount++;
            if (expectedValues.size() == 0) begin
                $display("unexpected corrValid at %0t ns with no result pending", $time);
                errorCount++;
            end else begin
                expectedValue = expectedValues.pop_front();
                expectedCycle = expectedCycles.pop_front();
                checkValue("corrOut", 32'(corrOut), 32'(expectedValue));
                checkValue("result cycle", 32'(cycleCount), 32'(expectedCycle));
            end
        end else if (corrValid !== 1'b0) begin
            $display("corrValid is unknown at %0t ns", $time);
            errorCount++;
        end else if (expectedCycles.size() != 0 && cycleCount > expectedCycles[0]) begin
            $display("result due at cycle %0d did not arrive by cycle %0d",
                     expectedCycles[0], cycleCount);
            errorCount++;
            expectedValue = expectedValues.pop_front();
            expectedCycle = expectedCycles.pop_front();
        end
        if (checkIdle) begin
            checkValue("corrOut while idle", 32'(corrOut), 32'd0);
        end
    endtask

    // One clock of stimulus, outputs checked before the new drive
    task automatic driveCycle(input logic valid, input logic bitVal, input logic load);
        @(negedge Clk);
        checkOutputs();
        bitValid    = valid;
        bitIn       = bitVal;
        loadPattern = load;
        updateModel(valid, bitVal, load);
    endtask

    task automatic drainCycles();
        repeat (DrainCycles) driveCycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic finishTest(input int number, input string name, input int errorsBefore);
        int pending;
        pending = expectedValues.size();
        if (pending != 0) begin
            $display("test %0d left %0d expected results that never arrived", number, pending);
            errorCount++;
            expectedValues.delete();
            expectedCycles.delete();
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d %s: ok", number, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed with %0d errors", number, name,
                     errorCount - errorsBefore);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic quietAfterReset();
        int errorsBefore;
        int resultsBefore;
        errorsBefore  = errorCount;
        resultsBefore = resultCount;
        checkIdle     = 1'b1;
        repeat (QuietCycles) driveCycle(randomBit(), randomBit(), 1'b0);
        drainCycles();
        checkIdle = 1'b0;
        checkValue("results while idle", 32'(resultCount - resultsBefore), 32'd0);
        finishTest(1, "quiet after reset", errorsBefore);
    endtask

    task automatic fullMatch();
        int errorsBefore;
        int resultsBefore;
        errorsBefore = errorCount;
        // Bit sent with the load request is dropped
        driveCycle(1'b1, randomBit(), 1'b1);
        for (int i = 0; i < WinBits; i++) begin
            patternSeq[i] = randomBit();
            driveCycle(1'b1, patternSeq[i], 1'b0);
        end
        resultsBefore = resultCount;
        for (int i = 0; i < WinBits; i++) begin
            driveCycle(1'b1, patternSeq[i], 1'b0);
        end
        drainCycles();
        checkValue("full match result count", 32'(resultCount - resultsBefore),
                   32'(WinBits / Osf));
        checkValue("full match final result", lastResult, 32'(WinBits));
        finishTest(2, "full match", errorsBefore);
    endtask

    task automatic fullMismatch();
        int errorsBefore;
        int resultsBefore;
        errorsBefore  = errorCount;
        resultsBefore = resultCount;
        for (int i = 0; i < WinBits; i++) begin
            driveCycle(1'b1, ~patternSeq[i], 1'b0);
        end
        drainCycles();
        checkValue("full mismatch result count", 32'(resultCount - resultsBefore),
                   32'(WinBits / Osf));
        checkValue("full mismatch final result", lastResult, 32'd0);
        finishTest(3, "full mismatch", errorsBefore);
    endtask

    task automatic randomStream();
        int   errorsBefore;
        logic valid;
        errorsBefore = errorCount;
        // Roughly one cycle in four without a bit
        for (int i = 0; i < RandomCycles; i++) begin
            valid = ($urandom % 4) != 0;
            driveCycle(valid, randomBit(), 1'b0);
        end
        drainCycles();
        finishTest(4, "random stream", errorsBefore);
    endtask

    task automatic patternReload();
        int errorsBefore;
        int resultsBefore;
        errorsBefore = errorCount;
        // Stop part way into a symbol
        while (modelSymbolCount != 2) begin
            driveCycle(1'b1, randomBit(), 1'b0);
        end
        driveCycle(1'b1, randomBit(), 1'b1);
        for (int i = 0; i < WinBits; i++) begin
            driveCycle(1'b1, randomBit(), 1'b0);
        end
        resultsBefore = resultCount;
        // Sample window still holds bits from before the reload
        for (int i = 0; i < WinBits + 2 * Osf; i++) begin
            driveCycle(1'b1, randomBit(), 1'b0);
        end
        drainCycles();
        checkValue("reload result count", 32'(resultCount - resultsBefore),
                   32'((WinBits + 2 * Osf) / Osf));
        finishTest(5, "pattern reload", errorsBefore);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(Seed));
        bitIn             = 1'b0;
        bitValid          = 1'b0;
        loadPattern       = 1'b0;
        modelPhase        = PhaseIdle;
        modelPatternCount = 0;
        modelSymbolCount  = 0;
        for (int i = 0; i < WinBits; i++) begin
            modelPattern[i] = 1'b0;
            modelSample[i]  = 1'b0;
            patternSeq[i]   = 1'b0;
        end

        wait (rstN === 1'b1);

        quietAfterReset();
        fullMatch();
        fullMismatch();
        randomStream();
        patternReload();

        $display("tests run 5, passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns before the tests finished", WatchdogNs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
source/corrPkg.sv
source/shiftRegister.sv
source/bitSequencer.sv
source/correlationEngine.sv
source/corrTop.sv
verification/clockGen.sv
verification/corrTb.sv

/* build.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

# Compile the testbench together with the RTL
verilator --binary --timing -f verilog.f --top-module corrTb -Mdir "$BUILD_DIR" -o corrSim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# Run and keep the log for the result search
"./$BUILD_DIR/corrSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
